/* Bender.yml */
package:
  name: datapath

sources:
  - files:
      - hdl/cpuPkg.sv
      - hdl/registerFile.sv
      - hdl/memInterface.sv
      - hdl/aluUnit.sv
      - hdl/busUnit.sv
      - hdl/dataPath.sv
  - target: test
    files:
      - bench/dataPath_properties.sv
      - bench/dataPathTb.sv

/* bench/dataPathTb.sv */
// dataPathTb module: clock, reset, stimulus tasks, reference model, watchdog and error count
`timescale 1ns/1ns
`default_nettype none

module dataPathTb;
    import cpuPkg::*;

    localparam int clkPeriod  = 8;
    localparam int numRandom  = 20;
    localparam int plannedOps = 40 + 4 * numRandom;  // loads, alu runs and readbacks
    localparam int timeoutNs  = (plannedOps * 40 + 200) * clkPeriod;

    logic                   Clock;
    logic                   rstN;
    ctrlWord                ctrl;
    logic [dataWidth-1:0]   memDataIn;
    logic [dataWidth-1:0]   busValue;
    logic [dataWidth-1:0]   memAddr;
    logic                   aluDone;

    int                     errorCount;
    integer                 seed;
    logic [dataWidth-1:0]   regModel [16];   // expected register file contents
    logic [2*dataWidth-1:0] zModel;

    dataPath #(
        .numRegs (16)
    ) i_dataPath (
        .Clock     (Clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .memDataIn (memDataIn),
        .busValue  (busValue),
        .memAddr   (memAddr),
        .aluDone   (aluDone)
    );

    bind dataPath dataPathProperties propCheck (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .busValue (busValue),
        .aluDone  (aluDone)
    );

    initial begin
        Clock = 1'b0;
        forever #(clkPeriod / 2) Clock = ~Clock;
    end

    initial begin
        #(timeoutNs);
        $display("ERROR: the run timed out after %0d ns without finishing", timeoutNs);
        $display("Test failures found");
        $finish;
    end

    // expected ALU result, A is Y and B is the bus at the start
    function automatic logic [2*dataWidth-1:0] modelAlu(input aluOp f,
                                                        input logic [dataWidth-1:0] a,
                                                        input logic [dataWidth-1:0] b);
        int                            n;
        logic signed [2*dataWidth-1:0] sa;
        logic signed [2*dataWidth-1:0] sb;
        logic [dataWidth-1:0]          r;
        n  = b[4:0];
        sa = $signed(a);
        sb = $signed(b);
        case (f)
            opAdd:   r = a + b;
            opSub:   r = a - b;
            opAnd:   r = a & b;
            opOr:    r = a | b;
            opShr:   r = a >> n;
            opShra:  r = $signed(a) >>> n;
            opShl:   r = a << n;
            opRor:   r = (a >> n) | (a << (32 - n));
            opRol:   r = (a << n) | (a >> (32 - n));
            opNeg:   r = 32'd0 - b;
            opNot:   r = ~b;
            opMul:   return sa * sb;     // full signed product
            default: r = '0;
        endcase
        return {{dataWidth{1'b0}}, r};
    endfunction

    task automatic driveCtrl(input ctrlWord c, input logic [dataWidth-1:0] data = '0);
        @(posedge Clock);
        #1;
        ctrl      = c;
        memDataIn = data;
    endtask

    task automatic readSrc(input busSrc src, input logic [3:0] sel);
        ctrlWord c;
        c        = '0;
        c.src    = src;
        c.regSel = sel;
        driveCtrl(c);
    endtask

    task automatic compareBus(input logic [dataWidth-1:0] expected);
        @(negedge Clock);                // mid cycle, bus settled
        assert (busValue === expected) else begin
            errorCount++;
            $display("CHECK FAILED busValue got %h expected %h", busValue, expected);
        end
    endtask

    task automatic checkBus(input busSrc src, input logic [3:0] sel,
                            input logic [dataWidth-1:0] expected);
        readSrc(src, sel);
        compareBus(expected);
    endtask

    // memory data into MDR, then MDR into Rn
    task automatic loadReg(input logic [3:0] n, input logic [dataWidth-1:0] value);
        ctrlWord c;
        c         = '0;
        c.mdrIn   = 1'b1;
        c.memRead = 1'b1;
        driveCtrl(c, value);
        c        = '0;
        c.src    = srcMdr;
        c.regIn  = 1'b1;
        c.regSel = n;
        driveCtrl(c);
        regModel[n] = value;
    endtask

    task automatic runAlu(input aluOp f, input logic [3:0] ra, input logic [3:0] rb,
                          input logic [3:0] rd);
        ctrlWord c;
        int      cycles;
        c        = '0;
        c.src    = srcReg;
        c.regSel = rb;
        c.yIn    = 1'b1;
        driveCtrl(c);
        c          = '0;
        c.src      = srcReg;
        c.regSel   = ra;
        c.aluStart = 1'b1;
        c.op       = f;
        driveCtrl(c);
        driveCtrl('0);
        cycles = 0;
        do begin
            @(negedge Clock);
            cycles++;
        end while (!aluDone && cycles < 64);
        if (!aluDone) begin
            errorCount++;
            $display("ALU never raised aluDone for opcode %s", f.name());
        end
        zModel   = modelAlu(f, regModel[rb], regModel[ra]);
        c        = '0;
        c.src    = srcZLo;
        c.regIn  = 1'b1;
        c.regSel = rd;
        driveCtrl(c);
        compareBus(zModel[dataWidth-1:0]);
        regModel[rd] = zModel[dataWidth-1:0];
    endtask

    initial begin
        ctrlWord c;
        aluOp    f;
        int      totalErrors;
        ctrl       = '0;
        memDataIn  = '0;
        rstN       = 1'b0;
        errorCount = 0;
        seed       = 66356;
        for (int i = 0; i < 16; i++) begin
            regModel[i] = '0;
        end
        repeat (4) @(posedge Clock);
        #1 rstN = 1'b1;

        // everything reads zero after reset
        for (int s = 0; s <= 10; s++) begin
            checkBus(busSrc'(s), 4'd0, '0);
        end
        for (int i = 0; i < 16; i++) begin
            checkBus(srcReg, 4'(i), '0);
        end
        assert (aluDone === 1'b0) else begin
            errorCount++;
            $display("CHECK FAILED aluDone got %h expected 0", aluDone);
        end

        loadReg(4'd1, 32'h1111_0001);
        loadReg(4'd2, 32'hABC0_0012);
        loadReg(4'd3, 32'h0000_0008);
        loadReg(4'd15, 32'hF00D_CAFE);
        checkBus(srcMdr, 4'd0, 32'hF00D_CAFE);
        checkBus(srcReg, 4'd1, regModel[1]);
        checkBus(srcReg, 4'd2, regModel[2]);
        checkBus(srcReg, 4'd3, regModel[3]);
        checkBus(srcReg, 4'd15, regModel[15]);
        c        = '0;
        c.src    = srcReg;
        c.regSel = 4'd1;
        c.marIn  = 1'b1;
        driveCtrl(c);
        checkBus(srcMar, 4'd0, regModel[1]);
        assert (memAddr === regModel[1]) else begin
            errorCount++;
            $display("CHECK FAILED memAddr got %h expected %h", memAddr, regModel[1]);
        end
        c.regSel = 4'd2;                 // MDR from the bus this time
        c.marIn  = 1'b0;
        c.mdrIn  = 1'b1;
        driveCtrl(c);
        checkBus(srcMdr, 4'd0, regModel[2]);

        runAlu(opRol, 4'd3, 4'd2, 4'd4);
        checkBus(srcReg, 4'd4, 32'hC000_12AB);
        for (int k = 0; k <= 10; k++) begin
            runAlu(aluOp'(k), 4'd3, 4'd2, 4'd5);
            checkBus(srcReg, 4'd5, regModel[5]);
        end

        loadReg(4'd6, 32'hFFFF_FFF9);   // -7
        loadReg(4'd7, 32'h0012_3456);
        runAlu(opMul, 4'd7, 4'd6, 4'd8);
        checkBus(srcZHi, 4'd0, zModel[2*dataWidth-1:dataWidth]);
        checkBus(srcZLo, 4'd0, zModel[dataWidth-1:0]);
        c      = '0;
        c.src  = srcZHi;
        c.hiIn = 1'b1;
        driveCtrl(c);
        c      = '0;
        c.src  = srcZLo;
        c.loIn = 1'b1;
        driveCtrl(c);
        checkBus(srcHi, 4'd0, zModel[2*dataWidth-1:dataWidth]);
        checkBus(srcLo, 4'd0, zModel[dataWidth-1:0]);

        loadReg(4'd9, 32'h0000_1000);
        c        = '0;
        c.src    = srcReg;
        c.regSel = 4'd9;
        c.pcIn   = 1'b1;
        driveCtrl(c);
        checkBus(srcPc, 4'd0, 32'h0000_1000);
        c       = '0;
        c.incPc = 1'b1;
        driveCtrl(c);
        driveCtrl(c);
        checkBus(srcPc, 4'd0, 32'h0000_1008);
        c        = '0;
        c.src    = srcReg;
        c.regSel = 4'd1;
        c.pcIn   = 1'b1;
        c.incPc  = 1'b1;                 // load must win over the increment
        driveCtrl(c);
        checkBus(srcPc, 4'd0, regModel[1]);
        c        = '0;
        c.src    = srcReg;
        c.regSel = 4'd2;
        c.irIn   = 1'b1;
        driveCtrl(c);
        checkBus(srcIr, 4'd0, regModel[2]);
        c.regSel = 4'd15;
        c.irIn   = 1'b0;
        c.yIn    = 1'b1;
        driveCtrl(c);
        checkBus(srcY, 4'd0, regModel[15]);

        for (int k = 0; k < numRandom; k++) begin
            loadReg(4'd10, $random(seed));
            loadReg(4'd11, $random(seed));
            f = aluOp'({$random(seed)} % 12);
            runAlu(f, 4'd11, 4'd10, 4'd12);
            checkBus(srcReg, 4'd12, regModel[12]);
        end
        driveCtrl('0);
        @(negedge Clock);

        totalErrors = errorCount + i_dataPath.propCheck.failCount;
        $display("errors: %0d bench checks, %0d assertion failures",
                 errorCount, i_dataPath.propCheck.failCount);
        if (totalErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/dataPath_properties.sv */
// dataPathProperties module: concurrent assertions on the ALU start/finished handshake and the bus
`timescale 1ns/1ns
`default_nettype none

module dataPathProperties (
    input logic                         Clock,
    input logic                         rstN,
    input cpuPkg::ctrlWord              ctrl,
    input logic [cpuPkg::dataWidth-1:0] busValue,
    input logic                         aluDone
);
    import cpuPkg::*;

    logic busy;           // start taken, its aluDone not yet seen
    logic accepted;
    int   failCount = 0;  // read by the testbench at the end

    // the unit is idle again in the cycle that carries aluDone
    assign accepted = ctrl.aluStart && (!busy || aluDone);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (accepted) begin
            busy <= 1'b1;
        end else if (aluDone) begin
            busy <= 1'b0;
        end
    end

    donePulse: assert property (@(posedge Clock) disable iff (!rstN) aluDone |=> !aluDone)
        else begin
            failCount++;
            $error("aluDone stayed high for two cycles");
        end

    startWhileBusy: assert property (@(posedge Clock) disable iff (!rstN)
        ctrl.aluStart |-> (!busy || aluDone))
        else begin
            failCount++;
            $error("aluStart arrived while the ALU was busy");
        end

    singleLatency: assert property (@(posedge Clock) disable iff (!rstN)
        accepted && ctrl.op != opMul |=> !aluDone ##1 aluDone)
        else begin
            failCount++;
            $error("single-cycle op did not finish one cycle after start");
        end

    mulLatency: assert property (@(posedge Clock) disable iff (!rstN)
        accepted && ctrl.op == opMul |=> !aluDone [*32] ##1 aluDone)
        else begin
            failCount++;
            $error("multiply did not finish 32 cycles after start");
        end

    busKnown: assert property (@(posedge Clock) disable iff (!rstN) !$isunknown(busValue))
        else begin
            failCount++;
            $error("busValue holds unknown bits");
        end

endmodule

`default_nettype wire

/* flist.f */
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/memInterface.sv
hdl/aluUnit.sv
hdl/busUnit.sv
hdl/dataPath.sv
bench/dataPath_properties.sv
bench/dataPathTb.sv

/* hdl/aluUnit.sv */
// aluUnit module: start/finished ALU with single-cycle ops, shift-and-add multiplier, Z register
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  logic                           Clock,
    input  logic                           rstN,
    input  logic                           aluStart,
    input  cpuPkg::aluOp                   op,
    input  logic [cpuPkg::dataWidth-1:0]   yValue,
    input  logic [cpuPkg::dataWidth-1:0]   bus,
    output logic [2*cpuPkg::dataWidth-1:0] zValue,
    output logic                           aluDone
);
    import cpuPkg::*;

    typedef enum logic {stIdle, stBusy} aluState;

    aluState                state;
    logic [4:0]             stepCount;    // remaining multiply steps
    logic                   startAccept;
    aluOp                   opReg;
    logic [dataWidth-1:0]   opA;          // from Y
    logic [dataWidth-1:0]   opB;          // from the bus
    logic [2*dataWidth-1:0] product;
    logic [dataWidth-1:0]   mcand;
    logic [dataWidth:0]     partialSum;   // one carry bit
    logic [2*dataWidth-1:0] productNext;
    logic [2*dataWidth-1:0] mulResult;
    logic                   negResult;

    function automatic logic [dataWidth-1:0] magnitude(input logic [dataWidth-1:0] v);
        return v[dataWidth-1] ? -v : v;
    endfunction

    function automatic logic [dataWidth-1:0] singleResult(input aluOp f,
                                                         input logic [dataWidth-1:0] a,
                                                         input logic [dataWidth-1:0] b);
        logic [4:0]             amt;
        logic [2*dataWidth-1:0] rotR;
        logic [2*dataWidth-1:0] rotL;
        amt  = b[4:0];                     // low 5 bits only
        rotR = {a, a} >> amt;
        rotL = {a, a} << amt;
        case (f)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opShr:   return a >> amt;
            opShra:  return $signed(a) >>> amt;
            opShl:   return a << amt;
            opRor:   return rotR[dataWidth-1:0];
            opRol:   return rotL[2*dataWidth-1:dataWidth];
            opNeg:   return -b;
            opNot:   return ~b;
            default: return '0;            // opMul handled by the iterative path
        endcase
    endfunction

    // a start while busy is dropped
    assign startAccept = aluStart && (state == stIdle);

    // unsigned shift-and-add on magnitudes with the sign applied at the end
    assign mcand       = magnitude(opA);
    assign partialSum  = {1'b0, product[2*dataWidth-1:dataWidth]}
                       + (product[0] ? {1'b0, mcand} : {(dataWidth + 1){1'b0}});
    assign productNext = {partialSum, product[dataWidth-1:1]};
    assign negResult   = opA[dataWidth-1] ^ opB[dataWidth-1];
    assign mulResult   = negResult ? -productNext : productNext;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            opReg   <= opAdd;
            opA     <= '0;
            opB     <= '0;
            product <= '0;
        end else if (startAccept) begin
            opReg   <= op;
            opA     <= yValue;
            opB     <= bus;
            product <= {{dataWidth{1'b0}}, magnitude(bus)};  // multiplier in low half
        end else if (state == stBusy && opReg == opMul) begin
            product <= productNext;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state     <= stIdle;
            stepCount <= '0;
            aluDone   <= 1'b0;
            zValue    <= '0;
        end else begin
            aluDone <= 1'b0;               // pulse lasts one cycle
            case (state)
                stIdle: begin
                    if (startAccept) begin
                        state     <= stBusy;
                        stepCount <= (op == opMul) ? 5'd31 : 5'd0;
                    end
                end
                stBusy: begin
                    if (stepCount == 5'd0) begin
                        state   <= stIdle;
                        aluDone <= 1'b1;
                        if (opReg == opMul) begin
                            zValue <= mulResult;
                        end else begin
                            zValue <= {{dataWidth{1'b0}}, singleResult(opReg, opA, opB)};
                        end
                    end else begin
                        stepCount <= stepCount - 5'd1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/busUnit.sv */
// busUnit module: PC, IR, Y, HI and LO registers and the shared bus multiplexer
`timescale 1ns/1ns
`default_nettype none

module busUnit (
    input  logic                           Clock,
    input  logic                           rstN,
    input  cpuPkg::ctrlWord                ctrl,
    input  logic [cpuPkg::dataWidth-1:0]   regData,
    input  logic [cpuPkg::dataWidth-1:0]   mdrValue,
    input  logic [cpuPkg::dataWidth-1:0]   marValue,
    input  logic [2*cpuPkg::dataWidth-1:0] zValue,
    output logic [cpuPkg::dataWidth-1:0]   bus,
    output logic [cpuPkg::dataWidth-1:0]   yValue
);
    import cpuPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] ir;
    logic [dataWidth-1:0] y;
    logic [dataWidth-1:0] hi;
    logic [dataWidth-1:0] lo;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            y  <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;                 // a jump overrides the increment
            end else if (ctrl.incPc) begin
                pc <= pc + 32'd4;
            end
            if (ctrl.irIn) ir <= bus;
            if (ctrl.yIn) y <= bus;
            if (ctrl.hiIn) hi <= bus;
            if (ctrl.loIn) lo <= bus;
        end
    end

    assign yValue = y;  // operand A of the ALU

    // exactly one source, chosen by the enum
    always_comb begin
        case (ctrl.src)
            srcNone: bus = '0;
            srcReg:  bus = regData;
            srcPc:   bus = pc;
            srcIr:   bus = ir;
            srcY:    bus = y;
            srcZLo:  bus = zValue[dataWidth-1:0];
            srcZHi:  bus = zValue[2*dataWidth-1:dataWidth];
            srcMar:  bus = marValue;
            srcHi:   bus = hi;
            srcLo:   bus = lo;
            srcMdr:  bus = mdrValue;
            default: bus = '0;             // unused codes read zero
        endcase
    end

endmodule

`default_nettype wire

/* hdl/cpuPkg.sv */
// cpuPkg package: data width, bus source and ALU opcode enums, per-cycle control word struct
`default_nettype none

package cpuPkg;

    // width of the shared bus and of every register
    localparam int dataWidth = 32;

    // single driver of the shared bus, srcNone reads zero
    typedef enum logic [3:0] {
        srcNone = 4'd0,
        srcReg  = 4'd1,   // general register named by regSel
        srcPc   = 4'd2,
        srcIr   = 4'd3,
        srcY    = 4'd4,
        srcZLo  = 4'd5,   // low half of the ALU result
        srcZHi  = 4'd6,   // high half, product upper word
        srcMar  = 4'd7,
        srcHi   = 4'd8,
        srcLo   = 4'd9,
        srcMdr  = 4'd10
    } busSrc;

    // ALU opcodes, all single cycle except opMul
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opShr  = 4'd4,    // logical right
        opShra = 4'd5,    // arithmetic right
        opShl  = 4'd6,
        opRor  = 4'd7,
        opRol  = 4'd8,
        opNeg  = 4'd9,
        opNot  = 4'd10,
        opMul  = 4'd11    // signed 32x32, iterative
    } aluOp;

    // one cycle of control from the sequencer
    typedef struct packed {
        busSrc      src;       // who drives the bus this cycle
        logic [3:0] regSel;    // register file entry
        logic       regIn;
        logic       pcIn;
        logic       incPc;     // pc + 4, pcIn has priority
        logic       irIn;
        logic       yIn;
        logic       hiIn;
        logic       loIn;
        logic       marIn;
        logic       mdrIn;
        logic       memRead;   // mdr source: memory data when high, bus otherwise
        logic       aluStart;  // one cycle pulse
        aluOp       op;
    } ctrlWord;

endpackage

`default_nettype wire

/* hdl/dataPath.sv */
// dataPath module: top level joining register file, memory interface, ALU and bus unit
`timescale 1ns/1ns
`default_nettype none

module dataPath #(
    parameter int numRegs = 16
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  cpuPkg::ctrlWord              ctrl,
    input  logic [cpuPkg::dataWidth-1:0] memDataIn,
    output logic [cpuPkg::dataWidth-1:0] busValue,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic                         aluDone
);
    import cpuPkg::*;

    logic [dataWidth-1:0]   regData;
    logic [dataWidth-1:0]   mdrValue;
    logic [dataWidth-1:0]   yValue;
    logic [2*dataWidth-1:0] zValue;

    registerFile #(
        .numRegs (numRegs)
    ) i_registerFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .regSel  (ctrl.regSel),
        .regIn   (ctrl.regIn),
        .bus     (busValue),
        .regData (regData)
    );

    // MAR output doubles as the memory address
    memInterface i_memInterface (
        .Clock     (Clock),
        .rstN      (rstN),
        .mdrIn     (ctrl.mdrIn),
        .memRead   (ctrl.memRead),
        .marIn     (ctrl.marIn),
        .bus       (busValue),
        .memDataIn (memDataIn),
        .mdrValue  (mdrValue),
        .marValue  (memAddr)
    );

    aluUnit i_aluUnit (
        .Clock    (Clock),
        .rstN     (rstN),
        .aluStart (ctrl.aluStart),
        .op       (ctrl.op),
        .yValue   (yValue),
        .bus      (busValue),
        .zValue   (zValue),
        .aluDone  (aluDone)
    );

    busUnit i_busUnit (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .regData  (regData),
        .mdrValue (mdrValue),
        .marValue (memAddr),
        .zValue   (zValue),
        .bus      (busValue),
        .yValue   (yValue)
    );

endmodule

`default_nettype wire

/* hdl/memInterface.sv */
// memInterface module: memory data register and memory address register
`timescale 1ns/1ns
`default_nettype none

module memInterface (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         mdrIn,
    input  logic                         memRead,
    input  logic                         marIn,
    input  logic [cpuPkg::dataWidth-1:0] bus,
    input  logic [cpuPkg::dataWidth-1:0] memDataIn,
    output logic [cpuPkg::dataWidth-1:0] mdrValue,
    output logic [cpuPkg::dataWidth-1:0] marValue
);
    import cpuPkg::*;

    logic [dataWidth-1:0] mdrNext;

    // memory side wins when a read is in progress
    assign mdrNext = memRead ? memDataIn : bus;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrIn) begin
            mdrValue <= mdrNext;
        end
    end

    // MAR feeds both the bus mux and the memory address pins
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            marValue <= '0;
        end else if (marIn) begin
            marValue <= bus;
        end
    end

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
// registerFile module: general purpose registers with one bus read port and one bus write port
`timescale 1ns/1ns
`default_nettype none

module registerFile #(
    parameter int numRegs = 16
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic [3:0]                   regSel,
    input  logic                         regIn,
    input  logic [cpuPkg::dataWidth-1:0] bus,
    output logic [cpuPkg::dataWidth-1:0] regData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [numRegs];
    logic                 selValid;

    // entries past numRegs do not exist
    assign selValid = (regSel < numRegs);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn && selValid) begin
            regs[regSel] <= bus;
        end
    end

    // combinational read, zero for a missing entry
    always_comb begin
        if (selValid) begin
            regData = regs[regSel];
        end else begin
            regData = '0;
        end
    end

endmodule

`default_nettype wire
